//--- list.f
+incdir+rtl
rtl/debug_pkg.sv
rtl/debug_fsm.sv
rtl/program_loader.sv
rtl/run_control.sv
rtl/result_dump.sv
rtl/debug_unit.sv
tests/tb_debug_unit.sv

//--- run.sh
#!/bin/sh
# Builds the debug unit testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f list.f \
  --top-module tb_debug_unit -o tb_debug_unit \
  && ./obj_dir/tb_debug_unit > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tests/tb_debug_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_macros.svh"

module tb_debug_unit;

  import debug_pkg::*;

  localparam int    N_TESTS    = 3;
  localparam int    ACK_DELAY  = 6;             // Cycles before the processor acks reset.
  localparam int    WAIT_LIMIT = 2000;
  localparam word_t LFSR_SEED  = 32'h129c6904;
  localparam int    W_RESET_LOW = 0;
  localparam int    W_TX_START  = 1;
  localparam int    W_DUMP      = 2;

  logic clock;
  logic reset;
  logic rx_done;
  byte_t rx_data;
  logic tx_done = 1'b0;
  logic soft_reset_ack = 1'b1;
  logic flag_halt = 1'b0;
  word_t result_word = '0;
  logic o_tx_start, o_soft_reset, o_mem_write, o_enable_pc, o_enable_pipeline;
  byte_t o_tx_data;
  addr_t o_mem_addr;
  word_t o_mem_data;
  dump_idx_t o_result_sel;

  int halt_after = 0;                           // Enabled cycles before HALT.
  int ack_delay = 0;
  int run_cycles = 0;
  int enable_count = 0;
  int pipe_mismatch = 0;
  int errors = 0;
  int timeouts = 0;
  int wr_addr_log [$];
  word_t wr_data_log [$];

  //////////////////////////////////////////////////////////////////////
  // Test table
  //////////////////////////////////////////////////////////////////////

  string name_tab [N_TESTS] = '{"run_short", "step_pair", "run_full"};
  int    len_tab  [N_TESTS] = '{3, 2, 4};
  logic  step_tab [N_TESTS] = '{1'b0, 1'b1, 1'b0};
  int    halt_tab [N_TESTS] = '{6, 2, 9};
  word_t prog_tab [N_TESTS][4] = '{
    '{32'h2001_0005, 32'h2002_0003, 32'h0022_1820, 32'h0000_0000},
    '{32'h3c04_1234, 32'h3484_5678, 32'h0000_0000, 32'h0000_0000},
    '{32'h8c05_0004, 32'hac05_0008, 32'h10a0_0002, 32'h0000_0000}
  };
  byte_t ack_tab [4] = '{`ACK_B0, `ACK_B1, `ACK_B2, `ACK_B3};  // Indexed by byte.

  debug_unit dut (
    .i_clock (clock), .i_reset (reset), .i_rx_done (rx_done), .i_rx_data (rx_data),
    .i_tx_done (tx_done), .i_soft_reset_ack (soft_reset_ack), .i_flag_halt (flag_halt),
    .i_result_word (result_word), .o_tx_start (o_tx_start), .o_tx_data (o_tx_data),
    .o_soft_reset (o_soft_reset), .o_mem_write (o_mem_write), .o_mem_addr (o_mem_addr),
    .o_mem_data (o_mem_data), .o_enable_pc (o_enable_pc),
    .o_enable_pipeline (o_enable_pipeline), .o_result_sel (o_result_sel)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic word_t lfsr_step(input word_t s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Each result word takes the next 32 LFSR bits after the words below it.
  function automatic word_t model_word(input dump_idx_t sel);
    word_t s;
    word_t w;
    int i;
    s = LFSR_SEED;
    w = '0;
    for (i = 0; i < 32 * int'(sel); i++) s = lfsr_step(s);
    for (i = 0; i < 32; i++) begin
      s = lfsr_step(s);
      w = {w[30:0], s[0]};
    end
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Processor model and monitor
  //////////////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    result_word <= model_word(o_result_sel);
    if (!reset || o_soft_reset) begin
      ack_delay      <= 0;
      soft_reset_ack <= 1'b1;
    end else if (ack_delay == ACK_DELAY) begin
      soft_reset_ack <= 1'b0;                   // Processor is now in reset.
    end else begin
      ack_delay <= ack_delay + 1;
    end
    if (!reset || !o_soft_reset) begin
      run_cycles <= 0;
      flag_halt  <= 1'b0;
    end else if (o_enable_pc) begin
      run_cycles <= run_cycles + 1;
      if (run_cycles + 1 >= halt_after) flag_halt <= 1'b1;
    end
  end

  always @(negedge clock) begin
    if (reset) begin
      if (o_enable_pc) enable_count++;
      if (o_enable_pipeline !== o_enable_pc) pipe_mismatch++;
      if (o_mem_write) begin
        wr_addr_log.push_back(int'(o_mem_addr));
        wr_data_log.push_back(o_mem_data);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks and waits
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("Run ended with %0d mismatches and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) $display("Everything OK");
    else $display("Something failed");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout: %s never happened", what);
    finish_run();
  endtask

  function automatic bit reached(input int what);
    case (what)
      W_RESET_LOW: return !o_soft_reset;
      W_TX_START:  return o_tx_start;
      W_DUMP:      return o_result_sel >= 4'd2;
      default:     return 1'b0;
    endcase
  endfunction

  task automatic wait_until(input int what, input string label);
    int n;
    n = 0;
    @(negedge clock);
    while (!reached(what)) begin
      if (n == WAIT_LIMIT) report_timeout(label);
      @(negedge clock);
      n++;
    end
  endtask

  // Host sends one byte as a receive pulse, then idles.
  task automatic send_byte(input byte_t b);
    @(posedge clock);
    rx_data <= b;
    rx_done <= 1'b1;
    @(posedge clock);
    rx_done <= 1'b0;
    repeat (3) @(posedge clock);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Host sequences
  //////////////////////////////////////////////////////////////////////

  task automatic reset_handshake(input string name);
    int n;
    n = 0;
    send_byte(`CMD_RESET);
    wait_until(W_RESET_LOW, {name, " soft reset"});
    while (!o_tx_start) begin
      check_value({name, " reset held"}, 32'd0, 32'(o_soft_reset));
      if (n == WAIT_LIMIT) report_timeout({name, " reset reply"});
      @(negedge clock);
      n++;
    end
    check_value({name, " reset released"}, 32'd1, 32'(o_soft_reset));
    check_value({name, " reset reply"}, 32'(`CMD_LOAD), 32'(o_tx_data));
  endtask

  task automatic load_program(input int t);
    int base;
    int i;
    int b;
    word_t w;
    base = wr_addr_log.size();
    send_byte(`CMD_LOAD);
    for (i = 0; i <= len_tab[t]; i++) begin
      w = (i == len_tab[t]) ? `HALT_INSTR : prog_tab[t][i];
      for (b = 3; b >= 0; b--) send_byte(w[b*8 +: 8]);  // MSB first.
    end
    @(negedge clock);
    check_value({name_tab[t], " writes"}, 32'(len_tab[t]), 32'(wr_addr_log.size() - base));
    for (i = 0; i < len_tab[t] && base + i < wr_addr_log.size(); i++) begin
      check_value({name_tab[t], " write addr"}, 32'(i), 32'(wr_addr_log[base + i]));
      check_value({name_tab[t], " write data"}, prog_tab[t][i], wr_data_log[base + i]);
    end
  endtask

  task automatic run_and_dump(input string name, input byte_t cmd, input int expect_en);
    int base;
    int w;
    int b;
    word_t expect_w;
    base = enable_count;
    send_byte(cmd);
    wait_until(W_DUMP, {name, " dump start"});
    check_value({name, " enabled cycles"}, 32'(expect_en), 32'(enable_count - base));
    for (w = 0; w < `DUMP_WORDS; w++) begin
      expect_w = model_word(dump_idx_t'(w + 2));
      for (b = 3; b >= 0; b--) begin
        wait_until(W_TX_START, {name, " dump byte"});
        check_value({name, " result sel"}, 32'(w + 2), 32'(o_result_sel));
        check_value({name, " dump byte"}, 32'(expect_w[b*8 +: 8]), 32'(o_tx_data));
        if (w == 0) begin
          send_byte(ack_tab[(b + 1) % 4]);      // Wrong ack must not advance.
          @(negedge clock);
          check_value({name, " held start"}, 32'd1, 32'(o_tx_start));
          check_value({name, " held byte"}, 32'(expect_w[b*8 +: 8]), 32'(o_tx_data));
        end
        send_byte(ack_tab[b]);
      end
    end
    @(negedge clock);
    check_value({name, " dump end"}, 32'd0, 32'(o_tx_start));
  endtask

  initial begin
    int t;
    int s;
    reset   <= 1'b0;
    rx_done <= 1'b0;
    rx_data <= '0;
    repeat (10) @(posedge clock);
    reset <= 1'b1;
    @(negedge clock);
    check_value("reset soft_reset", 32'd1, 32'(o_soft_reset));
    check_value("reset tx_start", 32'd0, 32'(o_tx_start));
    check_value("reset mem_write", 32'd0, 32'(o_mem_write));
    check_value("reset enable_pc", 32'd0, 32'(o_enable_pc));
    for (t = 0; t < N_TESTS; t++) begin
      halt_after = halt_tab[t];
      reset_handshake(name_tab[t]);             // Also proves the unit was idle.
      load_program(t);
      if (step_tab[t]) begin
        for (s = 0; s < halt_tab[t]; s++) run_and_dump(name_tab[t], `CMD_STEP, 1);
      end else begin
        run_and_dump(name_tab[t], `CMD_RUN, halt_tab[t]);
      end
    end
    reset_handshake("final idle");
    check_value("pipeline enable", 32'd0, 32'(pipe_mismatch));
    finish_run();
  end

endmodule

`default_nettype wire

//--- rtl/debug_unit.sv
`timescale 1ns/1ps
`default_nettype none

module debug_unit (
  input  logic                  i_clock,
  input  logic                  i_reset,
  input  logic                  i_rx_done,
  input  debug_pkg::byte_t      i_rx_data,
  input  logic                  i_tx_done,         // Unused UART transmit done.
  input  logic                  i_soft_reset_ack,
  input  logic                  i_flag_halt,
  input  debug_pkg::word_t      i_result_word,
  output logic                  o_tx_start,
  output debug_pkg::byte_t      o_tx_data,
  output logic                  o_soft_reset,      // Active low.
  output logic                  o_mem_write,
  output debug_pkg::addr_t      o_mem_addr,
  output debug_pkg::word_t      o_mem_data,
  output logic                  o_enable_pc,
  output logic                  o_enable_pipeline,
  output debug_pkg::dump_idx_t  o_result_sel
);

  import debug_pkg::*;

  dbg_state_t state;        // Broadcast FSM state.
  logic       rx_strobe;    // One cycle per accepted byte.
  logic       wait_ack_tx;
  logic       step_mode;
  logic       load_done;
  logic       run_done;
  logic       dump_done;

  debug_fsm u_fsm (
    .i_clock          (i_clock),
    .i_reset          (i_reset),
    .i_rx_done        (i_rx_done),
    .i_rx_data        (i_rx_data),
    .i_soft_reset_ack (i_soft_reset_ack),
    .i_flag_halt      (i_flag_halt),
    .i_step_mode      (step_mode),
    .i_load_done      (load_done),
    .i_run_done       (run_done),
    .i_dump_done      (dump_done),
    .o_state          (state),
    .o_rx_strobe      (rx_strobe),
    .o_soft_reset     (o_soft_reset),
    .o_wait_ack_tx    (wait_ack_tx)
  );

  program_loader u_loader (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_state     (state),
    .i_rx_strobe (rx_strobe),
    .i_rx_data   (i_rx_data),
    .o_mem_write (o_mem_write),
    .o_mem_addr  (o_mem_addr),
    .o_mem_data  (o_mem_data),
    .o_load_done (load_done)
  );

  run_control u_run (
    .i_clock           (i_clock),
    .i_reset           (i_reset),
    .i_state           (state),
    .i_rx_strobe       (rx_strobe),
    .i_rx_data         (i_rx_data),
    .i_flag_halt       (i_flag_halt),
    .o_step_mode       (step_mode),
    .o_enable_pc       (o_enable_pc),
    .o_enable_pipeline (o_enable_pipeline),
    .o_run_done        (run_done)
  );

  result_dump u_dump (
    .i_clock       (i_clock),
    .i_reset       (i_reset),
    .i_state       (state),
    .i_rx_strobe   (rx_strobe),
    .i_rx_data     (i_rx_data),
    .i_result_word (i_result_word),
    .i_wait_ack_tx (wait_ack_tx),
    .o_tx_start    (o_tx_start),
    .o_tx_data     (o_tx_data),
    .o_result_sel  (o_result_sel),
    .o_dump_done   (dump_done)
  );

endmodule

`default_nettype wire

//--- rtl/result_dump.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_macros.svh"

module result_dump (
  input  logic                  i_clock,
  input  logic                  i_reset,
  input  debug_pkg::dbg_state_t i_state,
  input  logic                  i_rx_strobe,
  input  debug_pkg::byte_t      i_rx_data,
  input  debug_pkg::word_t      i_result_word,
  input  logic                  i_wait_ack_tx,
  output logic                  o_tx_start,
  output debug_pkg::byte_t      o_tx_data,
  output debug_pkg::dump_idx_t  o_result_sel,
  output logic                  o_dump_done
);

  import debug_pkg::*;

  dump_idx_t word_idx;          // Word being sent.
  logic      in_send;
  logic      word_acked;        // Last byte of the word acknowledged.
  logic      last_word;

  assign in_send    = (i_state == send_b3) || (i_state == send_b2) ||
                      (i_state == send_b1) || (i_state == send_b0);
  assign word_acked = (i_state == send_b0) && i_rx_strobe && (i_rx_data == `ACK_B0);
  assign last_word  = (word_idx == dump_idx_t'(`DUMP_WORDS - 1));

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      word_idx <= '0;
    end else if (!in_send) begin
      word_idx <= '0;
    end else if (word_acked) begin
      word_idx <= last_word ? '0 : word_idx + 1'b1;
    end
  end

  always_comb begin
    case (i_state)
      send_b3: o_tx_data = i_result_word[31:24];
      send_b2: o_tx_data = i_result_word[23:16];
      send_b1: o_tx_data = i_result_word[15:8];
      send_b0: o_tx_data = i_result_word[7:0];
      default: o_tx_data = i_wait_ack_tx ? `CMD_LOAD : '0;  // Reset reply.
    endcase
  end

  assign o_tx_start   = in_send || i_wait_ack_tx;     // Held until acked.
  assign o_result_sel = in_send ? dump_idx_t'(word_idx + 4'd2) :
                        (i_state == execute) ? 4'd1 : 4'd0;
  assign o_dump_done  = word_acked && last_word;

endmodule

`default_nettype wire

//--- rtl/run_control.sv
`timescale 1ns/1ps
`default_nettype none

module run_control (
  input  logic                  i_clock,
  input  logic                  i_reset,
  input  debug_pkg::dbg_state_t i_state,
  input  logic                  i_rx_strobe,
  input  debug_pkg::byte_t      i_rx_data,
  input  logic                  i_flag_halt,
  output logic                  o_step_mode,
  output logic                  o_enable_pc,
  output logic                  o_enable_pipeline,
  output logic                  o_run_done
);

  import debug_pkg::*;

  localparam int MODE_BIT = 2;  // Command bit that selects step mode.

  logic step_q;                 // 0 continuous, 1 step.
  logic stepped_q;              // The single step has been issued.
  logic in_exec;
  logic run_en;

  assign in_exec = (i_state == execute);

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      step_q    <= 1'b0;
      stepped_q <= 1'b0;
    end else begin
      if ((i_state == wait_start) && i_rx_strobe) step_q <= i_rx_data[MODE_BIT];
      stepped_q <= in_exec && step_q;
    end
  end

  // Step mode runs one cycle; continuous mode runs until HALT.
  assign run_en     = in_exec && (step_q ? !stepped_q : !i_flag_halt);
  assign o_run_done = in_exec && (step_q ? stepped_q : i_flag_halt);

  assign o_step_mode       = step_q;
  assign o_enable_pc       = run_en;
  assign o_enable_pipeline = run_en;

endmodule

`default_nettype wire

//--- rtl/program_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_macros.svh"

module program_loader (
  input  logic                  i_clock,
  input  logic                  i_reset,
  input  debug_pkg::dbg_state_t i_state,
  input  logic                  i_rx_strobe,
  input  debug_pkg::byte_t      i_rx_data,
  output logic                  o_mem_write,
  output debug_pkg::addr_t      o_mem_addr,
  output debug_pkg::word_t      o_mem_data,
  output logic                  o_load_done
);

  import debug_pkg::*;

  logic [1:0] byte_cnt;      // Bytes of the current word.
  addr_t      addr_q;
  word_t      word_q;        // Shift register, MSB first.
  word_t      word_next;
  logic       mem_write_q;
  logic       load_done_q;
  logic       in_load;
  logic       take_byte;
  logic       word_full;

  assign in_load   = (i_state == load);
  assign take_byte = in_load && i_rx_strobe;
  assign word_full = take_byte && (byte_cnt == 2'd3);  // Fourth byte.
  assign word_next = {word_q[`WORD_W-`BYTE_W-1:0], i_rx_data};

  always_ff @(posedge i_clock) begin
    if (take_byte) word_q <= word_next;
  end

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      byte_cnt    <= 2'd0;
      addr_q      <= '0;
      mem_write_q <= 1'b0;
      load_done_q <= 1'b0;
    end else begin
      mem_write_q <= word_full && (word_next != `HALT_INSTR);
      load_done_q <= word_full && (word_next == `HALT_INSTR);
      if (!in_load) begin
        byte_cnt <= 2'd0;                  // Fresh load each time.
        addr_q   <= '0;
      end else begin
        if (take_byte) byte_cnt <= byte_cnt + 2'd1;
        if (mem_write_q) addr_q <= addr_q + 1'b1;  // Step after the write.
      end
    end
  end

  assign o_mem_write = mem_write_q;
  assign o_mem_addr  = addr_q;
  assign o_mem_data  = word_q;
  assign o_load_done = load_done_q;

endmodule

`default_nettype wire

//--- rtl/debug_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "debug_macros.svh"

module debug_fsm (
  input  logic                  i_clock,
  input  logic                  i_reset,
  input  logic                  i_rx_done,
  input  debug_pkg::byte_t      i_rx_data,
  input  logic                  i_soft_reset_ack,  // Active low.
  input  logic                  i_flag_halt,
  input  logic                  i_step_mode,
  input  logic                  i_load_done,
  input  logic                  i_run_done,
  input  logic                  i_dump_done,
  output debug_pkg::dbg_state_t o_state,
  output logic                  o_rx_strobe,
  output logic                  o_soft_reset,
  output logic                  o_wait_ack_tx
);

  import debug_pkg::*;

  dbg_state_t state;
  dbg_state_t state_next;
  logic       rx_done_q;
  logic       rx_strobe;

  // A byte counts on the falling edge of the receive pulse.
  assign rx_strobe = ~i_rx_done & rx_done_q;

  //////////////////////////////////////////////////////////////////////
  // State and edge registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge i_clock) begin
    if (!i_reset) begin
      state     <= idle;
      rx_done_q <= 1'b0;
    end else begin
      state     <= state_next;
      rx_done_q <= i_rx_done;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;                              // Hold by default.
    case (state)
      idle: begin
        if (rx_strobe && (i_rx_data == `CMD_RESET)) state_next = soft_reset;
      end
      soft_reset: begin
        if (!i_soft_reset_ack) state_next = wait_ack;  // Processor is in reset.
      end
      wait_ack: begin
        if (rx_strobe && (i_rx_data == `CMD_LOAD)) state_next = load;
      end
      load: begin
        if (i_load_done) state_next = wait_start;      // HALT received.
      end
      wait_start: begin
        if (rx_strobe && ((i_rx_data == `CMD_RUN) || (i_rx_data == `CMD_STEP))) begin
          state_next = execute;
        end
      end
      execute: begin
        if (i_run_done) state_next = send_b3;
      end
      send_b3: begin
        if (rx_strobe && (i_rx_data == `ACK_B3)) state_next = send_b2;
      end
      send_b2: begin
        if (rx_strobe && (i_rx_data == `ACK_B2)) state_next = send_b1;
      end
      send_b1: begin
        if (rx_strobe && (i_rx_data == `ACK_B1)) state_next = send_b0;
      end
      send_b0: begin
        if (rx_strobe && (i_rx_data == `ACK_B0)) begin
          if (!i_dump_done) begin
            state_next = send_b3;                    // Next result word.
          end else if (!i_step_mode || i_flag_halt) begin
            state_next = idle;                       // Program finished.
          end else begin
            state_next = wait_start;                 // Await next step.
          end
        end
      end
      default: state_next = idle;
    endcase
  end

  assign o_state       = state;
  assign o_rx_strobe   = rx_strobe;
  assign o_soft_reset  = (state != soft_reset);    // Low only while resetting.
  assign o_wait_ack_tx = (state == wait_ack);

endmodule

`default_nettype wire

//--- rtl/debug_pkg.sv
`default_nettype none

`include "debug_macros.svh"

package debug_pkg;

  typedef logic [`BYTE_W-1:0] byte_t;  // One UART byte.
  typedef logic [`WORD_W-1:0] word_t;  // Instruction or result.
  typedef logic [`ADDR_W-1:0] addr_t;  // Program memory address.

  // Result bank select with 0 idle, 1 execution and 2 up for the words.
  typedef logic [3:0] dump_idx_t;

  // Command FSM states, one-hot.
  typedef enum logic [9:0] {
    idle       = 10'b00_0000_0001,  // Waits for soft reset command.
    soft_reset = 10'b00_0000_0010,  // Holds processor in reset.
    wait_ack   = 10'b00_0000_0100,  // Replies and waits for load.
    load       = 10'b00_0000_1000,  // Receives program bytes.
    wait_start = 10'b00_0001_0000,  // Waits for run or step.
    execute    = 10'b00_0010_0000,
    send_b3    = 10'b00_0100_0000,  // Most significant byte.
    send_b2    = 10'b00_1000_0000,
    send_b1    = 10'b01_0000_0000,
    send_b0    = 10'b10_0000_0000   // Least significant byte.
  } dbg_state_t;

endpackage

`default_nettype wire

//--- rtl/debug_macros.svh
`ifndef DEBUG_MACROS_SVH
`define DEBUG_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////////////////////////

`define BYTE_W      8              // UART byte.
`define WORD_W      32             // Instruction and result word.
`define ADDR_W      11             // Program memory address.

`define DUMP_WORDS  10             // Result words per dump.
`define HALT_INSTR  32'hFFFF_FFFF  // Ends a program load.

//////////////////////////////////////////////////////////////////////
// Host protocol bytes
//////////////////////////////////////////////////////////////////////

`define CMD_RESET   8'h00          // Soft reset request.
`define CMD_LOAD    8'h01          // Load program and the reset reply.
`define CMD_RUN     8'h03          // Continuous mode.
`define CMD_STEP    8'h07          // Step mode.

// Host acks for the four bytes of a dump word.
`define ACK_B3      8'h08
`define ACK_B2      8'h10
`define ACK_B1      8'h18
`define ACK_B0      8'h20

`endif
